// File: bram_fifo/bram_fifo_core.sv
`default_nettype none

module bram_fifo_core import hit_readout_pkg::*; (
    input  logic         BUS_CLK,
    input  logic         RST,
    input  push_t        push,
    output logic         word_ready,
    input  reg_req_t     req,
    output reg_t         reg_rdata,
    input  logic         pop,
    output word_t        pop_data,
    output logic         empty,
    output fifo_status_t status
);

    logic   soft_rst;
    logic   int_rst;
    reg_t   af_value;
    reg_t   ae_value;
    reg_t   rd_err;
    logic   near_full;
    logic   fifo_full;
    logic   fifo_empty;
    level_t size;
    level_t af_level;
    level_t ae_level;

    // write to address 0 clears everything for that one cycle
    assign soft_rst = req.wr && (req.addr == ADDR_SOFT_RST);
    assign int_rst  = RST || soft_rst;

    always_ff @(posedge BUS_CLK) begin
        if (int_rst) begin
            af_value <= AF_DEFAULT;
            ae_value <= AE_DEFAULT;
        end else if (req.wr) begin
            if (req.addr == ADDR_AF)
                af_value <= req.wdata;
            if (req.addr == ADDR_AE)
                ae_value <= req.wdata;
        end
    end

    // register read, value is ready one cycle after the strobe
    always_ff @(posedge BUS_CLK) begin
        if (req.rd) begin
            case (req.addr)
                ADDR_SIZE0:  reg_rdata <= size[7:0];
                ADDR_SIZE1:  reg_rdata <= size[15:8];
                ADDR_SIZE2:  reg_rdata <= size[23:16];
                ADDR_RD_ERR: reg_rdata <= rd_err;
                default:     reg_rdata <= '0;
            endcase
        end
    end

    assign word_ready = !fifo_full;  // keep pulling while there is room

    sram_fifo i_sram_fifo (
        .BUS_CLK (BUS_CLK),
        .RST     (int_rst),
        .write   (push.valid),
        .wdata   (push.word),
        .read    (pop),
        .rdata   (pop_data),
        .full    (fifo_full),
        .empty   (fifo_empty),
        .size    (size)
    );

    // pops on an empty FIFO, saturating
    always_ff @(posedge BUS_CLK) begin
        if (int_rst)
            rd_err <= '0;
        else if (pop && fifo_empty && rd_err != 8'hff)
            rd_err <= rd_err + 1'b1;
    end

    // byte thresholds scaled to the FIFO depth
    assign af_level = level_t'(((int'(af_value) + 1) * FIFO_DEPTH) >> 8);
    assign ae_level = level_t'(((int'(ae_value) + 1) * FIFO_DEPTH) >> 8);

    // set high, clear low, hold in between
    always_ff @(posedge BUS_CLK) begin
        if (int_rst)
            near_full <= 1'b0;
        else if (size >= af_level || af_value == '0)
            near_full <= 1'b1;
        else if ((size <= ae_level && ae_value != '0) || size == '0)
            near_full <= 1'b0;
    end

    assign empty = fifo_empty;

    assign status.not_empty  = !fifo_empty;
    assign status.full       = fifo_full;
    assign status.near_full  = near_full;
    assign status.read_error = (rd_err != '0);

endmodule

`default_nettype wire

// File: bram_fifo/sram_fifo.sv
`default_nettype none

module sram_fifo import hit_readout_pkg::*; (
    input  logic   BUS_CLK,
    input  logic   RST,
    input  logic   write,
    input  word_t  wdata,
    input  logic   read,
    output word_t  rdata,
    output logic   full,
    output logic   empty,
    output level_t size
);

    word_t mem [FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    level_t           count;
    logic             do_wr;
    logic             do_rd;

    assign full  = (count == level_t'(FIFO_DEPTH));
    assign empty = (count == '0);
    assign size  = count;

    // write on full and read on empty are dropped
    assign do_wr = write && !full;
    assign do_rd = read && !empty;

    always_ff @(posedge BUS_CLK) begin
        if (RST) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr)
                wr_ptr <= wr_ptr + 1'b1;  // depth is a power of two, wraps
            if (do_rd)
                rd_ptr <= rd_ptr + 1'b1;

            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (do_wr)
            mem[wr_ptr] <= wdata;
    end

    // registered read port, block RAM style
    always_ff @(posedge BUS_CLK) begin
        if (do_rd)
            rdata <= mem[rd_ptr];
    end

endmodule

`default_nettype wire

// File: common/hit_readout_pkg.sv
`default_nettype none

package hit_readout_pkg;

    typedef logic [15:0] sample_t;  // one hit sample
    typedef logic [31:0] word_t;    // two samples packed
    typedef logic [23:0] level_t;   // fill level in words
    typedef logic [7:0]  paddr_t;
    typedef logic [7:0]  reg_t;

    typedef struct packed {
        logic    valid;
        sample_t sample;
    } hit_t;

    typedef struct packed {
        logic  valid;
        word_t word;
    } push_t;

    // single-cycle strobes into the register bank
    typedef struct packed {
        logic   wr;
        logic   rd;
        paddr_t addr;
        reg_t   wdata;
    } reg_req_t;

    typedef struct packed {
        logic not_empty;
        logic full;
        logic near_full;
        logic read_error;
    } fifo_status_t;

    localparam int FIFO_DEPTH       = 64;
    localparam int PTR_W            = $clog2(FIFO_DEPTH);
    localparam int ALMOST_FULL_PCT  = 95;
    localparam int ALMOST_EMPTY_PCT = 5;

    // threshold defaults scaled to a byte, 242 and 12
    localparam reg_t AF_DEFAULT = reg_t'(255 * ALMOST_FULL_PCT / 100);
    localparam reg_t AE_DEFAULT = reg_t'(255 * ALMOST_EMPTY_PCT / 100);

    // register map, writes and reads share addresses 1 and 2
    localparam paddr_t ADDR_SOFT_RST = 8'd0;
    localparam paddr_t ADDR_AF       = 8'd1;
    localparam paddr_t ADDR_AE       = 8'd2;
    localparam paddr_t ADDR_SIZE0    = 8'd1;
    localparam paddr_t ADDR_SIZE1    = 8'd2;
    localparam paddr_t ADDR_SIZE2    = 8'd3;
    localparam paddr_t ADDR_RD_ERR   = 8'd4;
    localparam paddr_t ADDR_DATA     = 8'd16;
    localparam paddr_t REG_SPAN      = 8'd8;

endpackage

`default_nettype wire

// File: hit_packer/hit_packer.sv
`default_nettype none

module hit_packer import hit_readout_pkg::*; (
    input  logic  BUS_CLK,
    input  logic  RST,
    input  hit_t  hit,
    output logic  hit_ready,
    output push_t push,
    input  logic  word_ready
);

    logic    second;      // next sample is the upper half
    logic    word_valid;
    sample_t low_half;
    word_t   word_q;
    logic    accept;

    // stall only while a finished word is stuck at the buffer
    assign hit_ready = !(word_valid && !word_ready);
    assign accept    = hit.valid && hit_ready;

    always_ff @(posedge BUS_CLK) begin
        if (RST) begin
            second     <= 1'b0;
            word_valid <= 1'b0;
        end else begin
            if (accept)
                second <= !second;

            if (accept && second)
                word_valid <= 1'b1;  // new word replaces one that leaves now
            else if (word_ready)
                word_valid <= 1'b0;
        end
    end

    // sample and word holding registers
    always_ff @(posedge BUS_CLK) begin
        if (accept && !second)
            low_half <= hit.sample;
        if (accept && second)
            word_q <= {hit.sample, low_half};  // first sample in bits 15:0
    end

    assign push.valid = word_valid;
    assign push.word  = word_q;

endmodule

`default_nettype wire

// File: hit_readout.f
common/hit_readout_pkg.sv
hit_packer/hit_packer.sv
bram_fifo/sram_fifo.sv
bram_fifo/bram_fifo_core.sv
logic/apb_readout.sv
logic/hit_readout_top.sv
verification/readout_checker.sv
verification/tb_hit_readout.sv

// File: logic/apb_readout.sv
`default_nettype none

module apb_readout import hit_readout_pkg::*; (
    input  logic     BUS_CLK,
    input  logic     RST,
    input  logic     psel,
    input  logic     penable,
    input  logic     pwrite,
    input  paddr_t   paddr,
    input  word_t    pwdata,
    output word_t    prdata,
    output logic     pready,
    output logic     pslverr,
    output reg_req_t req,
    input  reg_t     reg_rdata,
    output logic     pop,
    input  word_t    pop_data,
    input  logic     empty
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT,
        ST_DONE
    } state_t;

    state_t state;
    logic   err_q;
    logic   is_reg;
    logic   is_data;
    logic   setup;
    logic   access;

    assign is_reg  = (paddr < REG_SPAN);
    assign is_data = (paddr == ADDR_DATA);
    assign setup   = psel && !penable;
    assign access  = psel && penable;

    always_ff @(posedge BUS_CLK) begin
        if (RST) begin
            state <= ST_IDLE;
            err_q <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (setup) begin
                        // data port is read only
                        err_q <= !(is_reg || (is_data && !pwrite));
                        state <= pwrite ? ST_DONE : ST_WAIT;  // writes skip the wait
                    end
                end
                ST_WAIT: begin
                    if (access) begin
                        if (is_data && empty)
                            err_q <= 1'b1;  // nothing to pop
                        state <= ST_DONE;
                    end else begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // strobes, reads in the first access cycle and writes in the only one
    assign req.rd    = (state == ST_WAIT) && access && is_reg;
    assign req.wr    = (state == ST_DONE) && access && pwrite && is_reg;
    assign req.addr  = paddr;
    assign req.wdata = pwdata[7:0];
    assign pop       = (state == ST_WAIT) && access && is_data;

    assign pready  = (state == ST_DONE);
    assign pslverr = (state == ST_DONE) && err_q;

    // zero on errors and outside the read data phase
    always_comb begin
        prdata = '0;
        if (state == ST_DONE && !pwrite && !err_q) begin
            if (is_data)
                prdata = pop_data;
            else
                prdata = {24'b0, reg_rdata};
        end
    end

endmodule

`default_nettype wire

// File: logic/hit_readout_top.sv
`default_nettype none

module hit_readout_top import hit_readout_pkg::*; (
    input  logic         BUS_CLK,
    input  logic         RST,
    input  hit_t         hit,
    output logic         hit_ready,
    input  logic         psel,
    input  logic         penable,
    input  logic         pwrite,
    input  paddr_t       paddr,
    input  word_t        pwdata,
    output word_t        prdata,
    output logic         pready,
    output logic         pslverr,
    output fifo_status_t status
);

    push_t    push;
    logic     word_ready;
    reg_req_t req;
    reg_t     reg_rdata;
    logic     pop;
    word_t    pop_data;
    logic     empty;

    hit_packer i_hit_packer (
        .BUS_CLK    (BUS_CLK),
        .RST        (RST),
        .hit        (hit),
        .hit_ready  (hit_ready),
        .push       (push),
        .word_ready (word_ready)
    );

    bram_fifo_core i_bram_fifo_core (
        .BUS_CLK    (BUS_CLK),
        .RST        (RST),
        .push       (push),
        .word_ready (word_ready),
        .req        (req),
        .reg_rdata  (reg_rdata),
        .pop        (pop),
        .pop_data   (pop_data),
        .empty      (empty),
        .status     (status)
    );

    // host side
    apb_readout i_apb_readout (
        .BUS_CLK    (BUS_CLK),
        .RST        (RST),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .req        (req),
        .reg_rdata  (reg_rdata),
        .pop        (pop),
        .pop_data   (pop_data),
        .empty      (empty)
    );

endmodule

`default_nettype wire

// File: verification/readout_checker.sv
`default_nettype none

module readout_checker import hit_readout_pkg::*; (
    input  logic         BUS_CLK,
    input  logic         RST,
    input  hit_t         hit,
    input  logic         hit_ready,
    input  logic         psel,
    input  logic         penable,
    input  logic         pwrite,
    input  paddr_t       paddr,
    input  word_t        pwdata,
    input  word_t        prdata,
    input  logic         pready,
    input  logic         pslverr,
    input  fifo_status_t status,
    input  int           row_num,
    input  logic [1:0]   row_op,
    input  word_t        row_exp,
    input  logic         row_done,
    output int           rows_passed,
    output int           rows_failed
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [1:0] OP_WR = 2'd1;  // same code as the testbench table

    word_t   words [$];  // oldest word first, a held packer word at the back
    sample_t low_half;
    logic    have_low;
    reg_t    af_value;
    reg_t    ae_value;
    reg_t    rd_err;
    logic    near_full;
    word_t   row_value;  // accepted samples, good pops or last register read
    int      row_errors;
    int      access_cycles;

    function automatic int fill_level();
        return (words.size() > FIFO_DEPTH) ? FIFO_DEPTH : words.size();
    endfunction

    task automatic compare(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h, expected %h (row %0d)", name, got, exp, row_num);
            row_errors++;
        end
    endtask

    // set at the upper level, clear at the lower one or on empty
    task automatic track_near_full();
        int lvl;
        int af_lvl;
        int ae_lvl;
        lvl    = fill_level();
        af_lvl = ((int'(af_value) + 1) * FIFO_DEPTH) / 256;
        ae_lvl = ((int'(ae_value) + 1) * FIFO_DEPTH) / 256;
        if (lvl >= af_lvl || af_value == 0)
            near_full = 1'b1;
        else if ((ae_value != 0 && lvl <= ae_lvl) || lvl == 0)
            near_full = 1'b0;
    endtask

    task automatic clear_buffer();
        words.delete();
        af_value  = 8'd242;  // 95 percent of a byte
        ae_value  = 8'd12;   // 5 percent
        rd_err    = '0;
        near_full = 1'b0;
    endtask

    task automatic check_transfer();
        word_t exp_data;
        logic  exp_err;
        int    lvl;
        exp_data = '0;
        exp_err  = (paddr >= REG_SPAN);
        lvl      = fill_level();
        if (pwrite) begin
            if (paddr == ADDR_SOFT_RST)
                clear_buffer();
            else if (paddr == ADDR_AF)
                af_value = pwdata[7:0];
            else if (paddr == ADDR_AE)
                ae_value = pwdata[7:0];
        end else if (paddr == ADDR_DATA) begin
            exp_err = (words.size() == 0);
            if (exp_err && rd_err != 8'hff)
                rd_err++;  // saturates at 255
            if (!exp_err) begin
                exp_data = words.pop_front();
                row_value++;
            end
        end else begin
            row_value = prdata;
            case (paddr)
                ADDR_SIZE0:  exp_data = lvl & 32'hff;
                ADDR_SIZE1:  exp_data = (lvl >> 8) & 32'hff;
                ADDR_SIZE2:  exp_data = (lvl >> 16) & 32'hff;
                ADDR_RD_ERR: exp_data = rd_err;
                default:     exp_data = '0;
            endcase
        end
        track_near_full();
        compare("pslverr", pslverr, exp_err);
        compare("pready latency", access_cycles, pwrite ? 1 : 2);
        if (!pwrite)
            compare("prdata", prdata, exp_data);
    endtask

    task automatic finish_row();
        int lvl;
        lvl = fill_level();
        compare("status.not_empty", status.not_empty, lvl != 0);
        compare("status.full", status.full, lvl == FIFO_DEPTH);
        compare("status.near_full", status.near_full, near_full);
        compare("status.read_error", status.read_error, rd_err != 0);
        compare("hit_ready", hit_ready, words.size() <= FIFO_DEPTH);
        if (row_op != OP_WR)
            compare("row result", row_value, row_exp);
        if (row_errors == 0)
            rows_passed++;
        else
            rows_failed++;
        $display("row %0d: %s", row_num, (row_errors == 0) ? "pass" : "fail");
        row_value  = '0;
        row_errors = 0;
    endtask

    // sampled mid cycle, inputs and outputs are settled here
    always @(negedge BUS_CLK) begin
        if (RST) begin
            clear_buffer();
            have_low      = 1'b0;
            access_cycles = 0;
            row_value     = '0;
            row_errors    = 0;
            rows_passed   = 0;
            rows_failed   = 0;
        end else begin
            if (hit.valid && hit_ready) begin
                if (have_low) begin
                    words.push_back({hit.sample, low_half});  // first sample low
                    track_near_full();
                end else begin
                    low_half = hit.sample;
                end
                have_low = !have_low;
                row_value++;
            end
            if (psel && penable) begin
                access_cycles++;
                if (pready) begin
                    check_transfer();
                    access_cycles = 0;
                end
            end
            if (row_done)
                finish_row();
        end
    end

endmodule

`default_nettype wire

// File: verification/tb_hit_readout.sv
`default_nettype none

module tb_hit_readout import hit_readout_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    typedef enum logic [1:0] {OP_HITS, OP_WR, OP_RD, OP_DRAIN} op_t;

    typedef struct packed {
        op_t         op;
        logic [15:0] arg;  // sample count, address or read count
        word_t       exp;  // write data or expected row result
    } row_t;

    localparam int NUM_ROWS    = 26;
    localparam int STALL_LIMIT = 8;  // cycles before a blocked burst gives up

    logic         BUS_CLK;
    logic         RST;
    hit_t         hit;
    logic         hit_ready;
    logic         psel;
    logic         penable;
    logic         pwrite;
    paddr_t       paddr;
    word_t        pwdata;
    word_t        prdata;
    logic         pready;
    logic         pslverr;
    fifo_status_t status;

    row_t        rows [NUM_ROWS];
    int          row_num;
    logic [1:0]  row_op;
    word_t       row_exp;
    logic        row_done;
    int          rows_passed;
    int          rows_failed;
    logic [15:0] lfsr;
    int          cycle_limit;
    int          cycles;

    hit_readout_top UUT (.*);

    readout_checker i_readout_checker (.*);

    initial begin
        BUS_CLK = 1'b0;
        forever #10 BUS_CLK = !BUS_CLK;
    end

    task automatic load_table();
        rows[0]  = '{OP_HITS,  16'd8,    32'd8};    // packing order
        rows[1]  = '{OP_RD,    16'd1,    32'd4};
        rows[2]  = '{OP_RD,    16'd2,    32'd0};
        rows[3]  = '{OP_RD,    16'd3,    32'd0};
        rows[4]  = '{OP_DRAIN, 16'd4,    32'd4};
        rows[5]  = '{OP_DRAIN, 16'd1,    32'd0};    // empty read
        rows[6]  = '{OP_RD,    16'd4,    32'd1};
        rows[7]  = '{OP_RD,    16'h20,   32'd0};    // unmapped
        rows[8]  = '{OP_HITS,  16'd140,  32'd130};  // back-pressure
        rows[9]  = '{OP_RD,    16'd1,    32'd64};
        rows[10] = '{OP_DRAIN, 16'd66,   32'd65};
        rows[11] = '{OP_RD,    16'd4,    32'd2};
        rows[12] = '{OP_WR,    16'd1,    32'd127};  // set at 32 words
        rows[13] = '{OP_WR,    16'd2,    32'd63};   // clear at 16 words
        rows[14] = '{OP_HITS,  16'd60,   32'd60};
        rows[15] = '{OP_HITS,  16'd4,    32'd4};
        rows[16] = '{OP_DRAIN, 16'd10,   32'd10};
        rows[17] = '{OP_DRAIN, 16'd6,    32'd6};
        rows[18] = '{OP_HITS,  16'd20,   32'd20};
        rows[19] = '{OP_WR,    16'd0,    32'd0};    // soft reset
        rows[20] = '{OP_RD,    16'd1,    32'd0};
        rows[21] = '{OP_RD,    16'd4,    32'd0};
        rows[22] = '{OP_HITS,  16'd100,  32'd100};
        rows[23] = '{OP_RD,    16'd1,    32'd50};
        rows[24] = '{OP_DRAIN, 16'd50,   32'd50};
        rows[25] = '{OP_DRAIN, 16'd1,    32'd0};
    endtask

    function automatic int row_cycles(input row_t r);
        case (r.op)
            OP_HITS:  return int'(r.arg) + STALL_LIMIT + 6;
            OP_DRAIN: return 4 * int'(r.arg) + 6;
            default:  return 10;
        endcase
    endfunction

    // galois LFSR, one step per sample bit
    function automatic sample_t next_sample();
        sample_t smp;
        int      b;
        smp = '0;
        for (b = 0; b < 16; b++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
            smp  = {smp[14:0], lfsr[0]};
        end
        return smp;
    endfunction

    task automatic send_hits(input int count);
        sample_t smp;
        int      sent;
        int      stall;
        logic    ready;
        sent  = 0;
        stall = 0;
        smp   = next_sample();
        while (sent < count && stall < STALL_LIMIT) begin
            hit.valid  = 1'b1;
            hit.sample = smp;
            ready      = hit_ready;  // register driven, settled by now
            @(posedge BUS_CLK);
            #2;
            if (ready) begin
                sent++;
                stall = 0;
                smp   = next_sample();
            end else begin
                stall++;
            end
        end
        hit.valid = 1'b0;
    endtask

    task automatic apb_transfer(input logic write, input paddr_t addr, input word_t data);
        psel    = 1'b1;  // setup phase
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = data;
        @(posedge BUS_CLK);
        #2;
        penable = 1'b1;
        while (!pready) begin
            @(posedge BUS_CLK);
            #2;
        end
        @(posedge BUS_CLK);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic run_row(input row_t r);
        case (r.op)
            OP_HITS: send_hits(int'(r.arg));
            OP_WR:   apb_transfer(1'b1, paddr_t'(r.arg), r.exp);
            OP_RD:   apb_transfer(1'b0, paddr_t'(r.arg), '0);
            default: repeat (int'(r.arg)) apb_transfer(1'b0, ADDR_DATA, '0);
        endcase
    endtask

    initial begin
        RST      = 1'b1;
        hit      = '0;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        row_num  = 0;
        row_op   = '0;
        row_exp  = '0;
        row_done = 1'b0;
        lfsr     = 16'd54;
        load_table();
        repeat (4) @(posedge BUS_CLK);
        #2;
        RST = 1'b0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            row_num = i;
            row_op  = rows[i].op;
            row_exp = rows[i].exp;
            run_row(rows[i]);
            repeat (3) @(posedge BUS_CLK);  // last word written, flags settled
            #2;
            row_done = 1'b1;
            @(posedge BUS_CLK);
            #2;
            row_done = 1'b0;
        end
        $display("rows passed: %0d, rows failed: %0d", rows_passed, rows_failed);
        if (rows_failed == 0 && rows_passed == NUM_ROWS)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

    // run length bound, twice the table estimate plus margin
    initial begin
        cycles = 0;
        wait (RST === 1'b0);
        cycle_limit = 100;
        for (int i = 0; i < NUM_ROWS; i++)
            cycle_limit += 2 * row_cycles(rows[i]);
        while (cycles < cycle_limit) begin
            @(posedge BUS_CLK);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", cycle_limit);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire
